// File: hdl/adxl_pkg.sv
// ------------------------------
// adxl355 burst reader constants
// spi timing, read command, buffer size and fsm states
// ------------------------------
`default_nettype none

package adxl_pkg;

  // spi clock enable
  localparam int CLK_DIV = 4;                  // clk cycles per spi half-bit
  localparam int DIV_W   = $clog2(CLK_DIV);    // divider counter width

  // sensor access
  localparam logic [7:0] CMD_READ = 8'h11;     // 8*2+1, read from XDATA3 on
  localparam int LEN_READ = 9;                 // x, y, z with 3 bytes each

  // sample buffer
  localparam int BUF_DEPTH = 64;               // words of {x flag, byte}
  localparam int BUF_AW    = 6;                // log2 of BUF_DEPTH

  // burst sequencer states
  typedef enum logic [2:0] {
    ST_IDLE,      // csn high, waiting for sync
    ST_SELECT,    // csn low for one half-bit before sclk starts
    ST_CMD,       // command byte on mosi
    ST_READ,      // LEN_READ data bytes from miso
    ST_DESELECT   // sclk parked low, csn still low
  } burst_state_t;

endpackage

`default_nettype wire

// File: hdl/spi_ctrl_if.sv
// ------------------------------
// control link between burst fsm and spi shifter
// ------------------------------
`default_nettype none

interface spi_ctrl_if;

  logic csn;          // chip select, low during a burst
  logic sclk_en;      // spi clock runs in command and read phase
  logic load_cmd;     // one clk pulse, loads the command register
  logic capture_en;   // bytes finished now go to the buffer
  logic direct_sel;   // host owns the sensor pins
  logic byte_done;    // a full byte went through the shifter

  modport fsm (
    output csn, sclk_en, load_cmd, capture_en, direct_sel,
    input  byte_done
  );

  modport shifter (
    input  csn, sclk_en, load_cmd, capture_en, direct_sel,
    output byte_done
  );

endinterface

`default_nettype wire

// File: hdl/spi_timer.sv
// ------------------------------
// spi timing
// clock enable divider, half-bit and byte counters
// ------------------------------
`default_nettype none

module spi_timer (
  input  logic       clk,
  input  logic       rst,
  input  logic       sclk_en,   // spi clock running
  input  logic       cnt_clr,   // restart byte count for a new burst
  output logic       tick,      // one spi half-bit
  output logic       byte_end,  // last half-bit of a byte
  output logic [3:0] half_cnt,  // even: sclk low, odd: sclk high
  output logic [3:0] byte_cnt   // bytes done in this burst
);
  import adxl_pkg::*;

  logic [DIV_W-1:0] div_cnt;

  // free running divider from clk
  always_ff @(posedge clk)
  begin
    if (rst)
      div_cnt <= '0;
    else if (div_cnt == DIV_W'(CLK_DIV - 1))
      div_cnt <= '0;
    else
      div_cnt <= div_cnt + 1'b1;
  end

  assign tick = (div_cnt == DIV_W'(CLK_DIV - 1));  // 1 clk every CLK_DIV clk

  // half-bit position inside the current byte
  always_ff @(posedge clk)
  begin
    if (rst || !sclk_en)
      half_cnt <= '0;                // parked at sclk low between bursts
    else if (tick)
      half_cnt <= half_cnt + 4'd1;   // 15 -> 0 closes the byte
  end

  assign byte_end = tick && sclk_en && (half_cnt == 4'd15);

  // byte index, 0 is the command
  always_ff @(posedge clk)
  begin
    if (rst || cnt_clr)
      byte_cnt <= '0;
    else if (byte_end)
      byte_cnt <= byte_cnt + 4'd1;
  end

endmodule

`default_nettype wire

// File: hdl/burst_fsm.sv
// ------------------------------
// burst sequencer
// select, command, LEN_READ data bytes, deselect
// ------------------------------
`default_nettype none

module burst_fsm (
  input  logic       clk,
  input  logic       rst,
  input  logic       sync,      // start of one xyz burst
  input  logic       direct,    // host asks for the sensor pins
  input  logic       tick,
  input  logic [3:0] byte_cnt,
  output logic       busy,
  output logic       cnt_clr,
  spi_ctrl_if.fsm    ctrl
);
  import adxl_pkg::*;

  burst_state_t state;
  burst_state_t state_nxt;

  logic start_pend;   // sync taken, burst starts at next tick
  logic direct_sel;   // latched direct request
  logic idle_free;    // idle with no burst pending
  logic start_ok;     // this sync starts a burst
  logic last_byte;

  assign idle_free = (state == ST_IDLE) && !start_pend;
  assign start_ok  = idle_free && sync && !direct_sel;   // other syncs are dropped
  assign last_byte = (byte_cnt == 4'(LEN_READ));         // command + LEN_READ bytes

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state      <= ST_IDLE;
      start_pend <= 1'b0;
      direct_sel <= 1'b0;
    end
    else
    begin
      state <= state_nxt;

      // mode only changes between bursts, never cuts one
      if (idle_free && !start_ok)
        direct_sel <= direct;

      if (start_ok)
        start_pend <= 1'b1;
      else if (tick)
        start_pend <= 1'b0;      // same tick moves idle -> select
    end
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_IDLE:
        if (tick && start_pend)
          state_nxt = ST_SELECT;
      ST_SELECT:
        if (tick)
          state_nxt = ST_CMD;    // csn was low for one half-bit
      ST_CMD:
        if (ctrl.byte_done && byte_cnt == 4'd0)
          state_nxt = ST_READ;
      ST_READ:
        if (ctrl.byte_done && last_byte)
          state_nxt = ST_DESELECT;
      ST_DESELECT:
        if (tick)
          state_nxt = ST_IDLE;   // csn rises here
      default:
        state_nxt = ST_IDLE;
    endcase
  end

  assign busy    = start_pend || (state != ST_IDLE);
  assign cnt_clr = (state == ST_SELECT);

  assign ctrl.csn        = (state == ST_IDLE);
  assign ctrl.sclk_en    = (state == ST_CMD) || (state == ST_READ);
  assign ctrl.load_cmd   = (state == ST_SELECT) && tick;   // one clk, enters ST_CMD
  assign ctrl.capture_en = (state == ST_READ);
  assign ctrl.direct_sel = direct_sel;

endmodule

`default_nettype wire

// File: hdl/spi_shifter.sv
// ------------------------------
// spi mode 0 shifter and pin mux
// command out, data bytes in, host pass-through
// ------------------------------
`default_nettype none

module spi_shifter (
  input  logic        clk,
  input  logic        rst,
  input  logic        tick,
  input  logic        byte_end,
  input  logic        direct_mosi,
  input  logic        direct_sclk,
  input  logic        direct_csn,
  input  logic        adxl_miso,
  input  logic [3:0]  half_cnt,
  spi_ctrl_if.shifter ctrl,
  output logic        adxl_mosi,
  output logic        adxl_sclk,
  output logic        adxl_csn,
  output logic        wr,         // one clk per stored byte
  output logic        x,          // first byte of the xyz sample
  output logic [7:0]  wrdata
);
  import adxl_pkg::*;

  logic [7:0] tx_sh;       // command, MSB on mosi
  logic [7:0] rx_sh;       // bits from miso
  logic       first_pend;  // next stored byte starts a sample
  logic       rise_tick;   // sclk goes high
  logic       fall_tick;   // sclk goes low
  logic       sclk_int;
  logic       store;

  assign sclk_int  = ctrl.sclk_en && half_cnt[0];
  assign rise_tick = tick && ctrl.sclk_en && !half_cnt[0];
  assign fall_tick = tick && ctrl.sclk_en && half_cnt[0];
  assign store     = byte_end && ctrl.capture_en;

  // mosi changes on the falling edge, sensor samples on the rise
  always_ff @(posedge clk)
  begin
    if (rst)
      tx_sh <= '0;
    else if (ctrl.load_cmd)
      tx_sh <= CMD_READ;
    else if (fall_tick)
      tx_sh <= {tx_sh[6:0], 1'b0};   // zero fill, mosi low while reading
  end

  // miso is stable since the last fall
  always_ff @(posedge clk)
  begin
    if (rise_tick)
      rx_sh <= {rx_sh[6:0], adxl_miso};
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr         <= 1'b0;
      x          <= 1'b0;
      first_pend <= 1'b0;
    end
    else
    begin
      wr <= store;                   // 1 clk after byte_end
      x  <= store && first_pend;
      if (ctrl.load_cmd)
        first_pend <= 1'b1;          // new burst, new sample
      else if (store)
        first_pend <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (store)
      wrdata <= rx_sh;               // last bit came in on the previous rise
  end

  assign ctrl.byte_done = byte_end;

  // host pins or internal engine, miso goes to both unmuxed
  assign adxl_csn  = ctrl.direct_sel ? direct_csn  : ctrl.csn;
  assign adxl_sclk = ctrl.direct_sel ? direct_sclk : sclk_int;
  assign adxl_mosi = ctrl.direct_sel ? direct_mosi : tx_sh[7];

endmodule

`default_nettype wire

// File: hdl/sample_buffer.sv
// ------------------------------
// circular sample buffer
// byte plus x flag per word, registered read port
// ------------------------------
`default_nettype none

module sample_buffer (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        wr,
  input  logic                        x,
  input  logic [7:0]                  wrdata,
  input  logic [adxl_pkg::BUF_AW-1:0] rd_addr,
  output logic [8:0]                  rd_data,   // {x, byte}
  output logic [adxl_pkg::BUF_AW-1:0] wr_addr    // next word to write
);
  import adxl_pkg::*;

  logic [8:0] mem [BUF_DEPTH];   // block ram style

  always_ff @(posedge clk)
  begin
    if (wr)
      mem[wr_addr] <= {x, wrdata};
  end

  // one clk read latency
  always_ff @(posedge clk)
  begin
    rd_data <= mem[rd_addr];
  end

  // write pointer wraps, old samples get overwritten
  always_ff @(posedge clk)
  begin
    if (rst)
      wr_addr <= '0;
    else if (wr)
    begin
      if (wr_addr == BUF_AW'(BUF_DEPTH - 1))
        wr_addr <= '0;
      else
        wr_addr <= wr_addr + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hdl/adxl_reader.sv
// ------------------------------
// adxl355 burst reader top
// timer, fsm, shifter and buffer
// ------------------------------
`default_nettype none

module adxl_reader (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        sync,         // start one burst
  input  logic                        direct,       // 1: host drives the sensor
  input  logic                        direct_mosi,
  input  logic                        direct_sclk,
  input  logic                        direct_csn,
  input  logic                        adxl_miso,    // host reads this directly too
  input  logic [adxl_pkg::BUF_AW-1:0] rd_addr,
  output logic                        adxl_mosi,
  output logic                        adxl_sclk,
  output logic                        adxl_csn,
  output logic                        busy,
  output logic [8:0]                  rd_data,
  output logic [adxl_pkg::BUF_AW-1:0] wr_addr
);

  logic       tick;
  logic       byte_end;
  logic       cnt_clr;
  logic [3:0] half_cnt;
  logic [3:0] byte_cnt;
  logic       wr;
  logic       x;
  logic [7:0] wrdata;

  spi_ctrl_if u_ctrl ();

  spi_timer u_spi_timer (
    .clk      (clk),
    .rst      (rst),
    .sclk_en  (u_ctrl.sclk_en),
    .cnt_clr  (cnt_clr),
    .tick     (tick),
    .byte_end (byte_end),
    .half_cnt (half_cnt),
    .byte_cnt (byte_cnt)
  );

  burst_fsm u_burst_fsm (
    .clk      (clk),
    .rst      (rst),
    .sync     (sync),
    .direct   (direct),
    .tick     (tick),
    .byte_cnt (byte_cnt),
    .busy     (busy),
    .cnt_clr  (cnt_clr),
    .ctrl     (u_ctrl.fsm)
  );

  spi_shifter u_spi_shifter (
    .clk         (clk),
    .rst         (rst),
    .tick        (tick),
    .byte_end    (byte_end),
    .direct_mosi (direct_mosi),
    .direct_sclk (direct_sclk),
    .direct_csn  (direct_csn),
    .adxl_miso   (adxl_miso),
    .half_cnt    (half_cnt),
    .ctrl        (u_ctrl.shifter),
    .adxl_mosi   (adxl_mosi),
    .adxl_sclk   (adxl_sclk),
    .adxl_csn    (adxl_csn),
    .wr          (wr),
    .x           (x),
    .wrdata      (wrdata)
  );

  sample_buffer u_sample_buffer (
    .clk     (clk),
    .rst     (rst),
    .wr      (wr),
    .x       (x),
    .wrdata  (wrdata),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .wr_addr (wr_addr)
  );

endmodule

`default_nettype wire

// File: tests/adxl_reader_chk.sv
// ------------------------------
// burst fsm checker
// csn, sclk and busy rules, bound into burst_fsm
// ------------------------------
`default_nettype none

module adxl_reader_chk (
  input logic                   clk,
  input logic                   rst,
  input adxl_pkg::burst_state_t state,
  input logic                   csn,
  input logic                   sclk_en,     // internal sclk can only be high with this
  input logic                   busy,
  input logic                   direct_sel
);
  timeunit 1ns;
  timeprecision 100ps;
  import adxl_pkg::*;

  // sensor selected a full half-bit before the first sclk edge
  csn_lead_sclk: assert property (@(posedge clk) disable iff (rst)
    $rose(sclk_en) |-> $past(!csn, CLK_DIV))
    else $error("spi clock started less than a half-bit after csn fell");

  csn_rise_parked: assert property (@(posedge clk) disable iff (rst)
    $rose(csn) |-> ($past(state == ST_DESELECT) && $past(!sclk_en, CLK_DIV)))
    else $error("csn rose without a half-bit of parked sclk in deselect");   // mode 0

  // no burst may start while the host owns the pins
  no_busy_in_direct: assert property (@(posedge clk) disable iff (rst)
    $rose(busy) |-> !direct_sel)
    else $error("busy rose in direct mode");

endmodule

bind burst_fsm adxl_reader_chk u_chk (
  .clk        (clk),
  .rst        (rst),
  .state      (state),
  .csn        (ctrl.csn),
  .sclk_en    (ctrl.sclk_en),
  .busy       (busy),
  .direct_sel (direct_sel)
);

`default_nettype wire

// File: tests/tb_adxl_reader.sv
// ------------------------------
// adxl355 burst reader testbench
// sensor model, bursts, direct mode, mode switch
// ------------------------------
`default_nettype none

module tb_adxl_reader;
  timeunit 1ns;
  timeprecision 100ps;
  import adxl_pkg::*;

  localparam int N_BURSTS    = 10;    // 1 single, 7 back to back, 2 in the switch test
  localparam int BURST_CYC   = CLK_DIV * (2 + 16 * (1 + LEN_READ)) + 60;
  localparam int WATCHDOG_NS = N_BURSTS * BURST_CYC * 10 + 20000;

  logic              clk = 1'b0;
  logic              rst;
  logic              sync;
  logic              direct;
  logic              direct_mosi;
  logic              direct_sclk;
  logic              direct_csn;
  logic              adxl_miso = 1'b0;   // driven by the sensor model
  logic [BUF_AW-1:0] rd_addr;
  logic              adxl_mosi;
  logic              adxl_sclk;
  logic              adxl_csn;
  logic              busy;
  logic [8:0]        rd_data;
  logic [BUF_AW-1:0] wr_addr;

  logic [7:0]  miso_q [$];          // bytes the sensor still has to send
  logic [7:0]  tx_sh = 8'h00;
  logic [7:0]  cmd_sh = 8'h00;
  logic [7:0]  rx_cmd = 8'h00;      // first byte of the last frame
  int          bit_cnt = 0;
  logic        prev_csn = 1'b1;
  logic        prev_sclk = 1'b0;
  logic [15:0] lfsr = 16'd30403;
  logic [7:0]  burst_bytes [LEN_READ];
  int          exp_wr;              // expected write pointer
  string       test_name;

  always #5 clk = ~clk;             // 10 ns

  adxl_reader u_adxl_reader (
    .clk         (clk),
    .rst         (rst),
    .sync        (sync),
    .direct      (direct),
    .direct_mosi (direct_mosi),
    .direct_sclk (direct_sclk),
    .direct_csn  (direct_csn),
    .adxl_miso   (adxl_miso),
    .rd_addr     (rd_addr),
    .adxl_mosi   (adxl_mosi),
    .adxl_sclk   (adxl_sclk),
    .adxl_csn    (adxl_csn),
    .busy        (busy),
    .rd_data     (rd_data),
    .wr_addr     (wr_addr)
  );

  // spi mode 0 slave, works on pin edges only
  always @(adxl_csn or adxl_sclk)
  begin
    if (adxl_csn === 1'b0 && prev_csn === 1'b1)
    begin
      bit_cnt = 0;                  // new frame
      cmd_sh = 8'h00;
      rx_cmd = 8'h00;
      adxl_miso = 1'b0;
    end
    else if (adxl_csn === 1'b0 && adxl_sclk === 1'b1 && prev_sclk === 1'b0)
    begin
      if (bit_cnt < 8)
        cmd_sh = {cmd_sh[6:0], adxl_mosi};
      bit_cnt = bit_cnt + 1;
      if (bit_cnt == 8)
        rx_cmd = cmd_sh;
    end
    else if (adxl_csn === 1'b0 && adxl_sclk === 1'b0 && prev_sclk === 1'b1)
    begin
      // data bytes only after the command, none after the last one
      if (bit_cnt >= 8 && bit_cnt < 8 * (1 + LEN_READ))
      begin
        if (bit_cnt % 8 == 0)
          tx_sh = (miso_q.size() > 0) ? miso_q.pop_front() : 8'h00;
        else
          tx_sh = {tx_sh[6:0], 1'b0};
        adxl_miso = tx_sh[7];       // msb first
      end
    end
    prev_csn = adxl_csn;
    prev_sclk = adxl_sclk;
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // x^16+x^14+x^13+x^11+1
  endfunction

  task automatic random_byte(output logic [7:0] b);
    b = 8'h00;
    for (int i = 0; i < 8; i++)
    begin
      lfsr = lfsr_next(lfsr);       // one step per bit
      b = {b[6:0], lfsr[0]};
    end
  endtask

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
    begin
      $display("Fail %s, %s: expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
      $display("Simulation finished: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic stop_run(input string why);
    $display("%s in test %s", why, test_name);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic pulse_sync();
    @(posedge clk);
    sync <= 1'b1;
    @(posedge clk);
    sync <= 1'b0;
  endtask

  task automatic wait_busy_rise();
    int n;
    n = 0;
    @(negedge clk);
    while (busy !== 1'b1 && n < 4)
    begin
      n++;
      @(negedge clk);
    end
    if (busy !== 1'b1)
      stop_run("busy did not rise after a sync pulse in idle");
  endtask

  task automatic read_word(input int addr, output logic [8:0] data);
    @(posedge clk);
    rd_addr <= BUF_AW'(addr);
    @(posedge clk);                 // rd_data registered here
    @(negedge clk);
    data = rd_data;
  endtask

  task automatic start_burst(output int base);
    base = exp_wr;
    for (int i = 0; i < LEN_READ; i++)
      miso_q.push_back(burst_bytes[i]);
    pulse_sync();
    wait_busy_rise();
  endtask

  task automatic finish_burst(input int base);
    logic [8:0] word;
    while (busy !== 1'b0)
      @(negedge clk);
    exp_wr = (exp_wr + LEN_READ) % BUF_DEPTH;
    check("command byte", CMD_READ, rx_cmd);
    check("wr_addr after burst", exp_wr, wr_addr);
    check("bytes left in sensor", 0, miso_q.size());
    for (int i = 0; i < LEN_READ; i++)
    begin
      read_word((base + i) % BUF_DEPTH, word);   // wraps at the buffer end
      check("stored byte", burst_bytes[i], word[7:0]);
      check("x flag", (i == 0), word[8]);
    end
  endtask

  task automatic run_burst(input bit extra_sync);
    int base;
    start_burst(base);
    if (extra_sync)
    begin
      repeat (100) @(posedge clk);
      pulse_sync();                 // busy, must be dropped
    end
    finish_burst(base);
    if (extra_sync)
    begin
      repeat (2 * CLK_DIV)
      begin
        @(negedge clk);
        check("busy after ignored sync", 0, busy);
      end
    end
  endtask

  task automatic test_reset();
    test_name = "reset";
    @(negedge clk);
    check("adxl_csn", 1, adxl_csn);
    check("adxl_sclk", 0, adxl_sclk);
    check("adxl_mosi", 0, adxl_mosi);
    check("busy", 0, busy);
    check("wr_addr", 0, wr_addr);
  endtask

  task automatic test_single_burst();
    test_name = "single burst";
    burst_bytes = '{8'hA5, 8'h5A, 8'h00, 8'hFF, 8'h01, 8'h80, 8'h3C, 8'hC3, 8'h7E};
    run_burst(1'b0);
  endtask

  task automatic test_back_to_back();
    test_name = "back to back";
    for (int b = 0; b < 7; b++)     // enough to pass the end of the buffer
    begin
      for (int i = 0; i < LEN_READ; i++)
        random_byte(burst_bytes[i]);
      run_burst(b == 1);
    end
  endtask

  task automatic test_direct();
    logic [2:0] pat;
    test_name = "direct mode";
    @(posedge clk);
    direct <= 1'b1;
    repeat (3) @(posedge clk);      // latched in idle
    for (int p = 0; p < 8; p++)
    begin
      pat = p[2:0];
      @(posedge clk);
      direct_csn  <= pat[2];
      direct_sclk <= pat[1];
      direct_mosi <= pat[0];
      @(negedge clk);
      check("adxl_csn", pat[2], adxl_csn);
      check("adxl_sclk", pat[1], adxl_sclk);
      check("adxl_mosi", pat[0], adxl_mosi);
    end
    @(posedge clk);
    direct_csn  <= 1'b1;
    direct_sclk <= 1'b0;
    direct_mosi <= 1'b0;
    pulse_sync();
    repeat (4 * CLK_DIV)
    begin
      @(negedge clk);
      check("busy with sync in direct mode", 0, busy);
    end
    check("wr_addr in direct mode", exp_wr, wr_addr);
    @(posedge clk);
    direct <= 1'b0;
    repeat (3) @(posedge clk);
  endtask

  task automatic test_switch();
    int base;
    test_name = "switch when idle";
    for (int i = 0; i < LEN_READ; i++)
      random_byte(burst_bytes[i]);
    start_burst(base);
    while (wr_addr !== BUF_AW'((base + 2) % BUF_DEPTH))
      @(negedge clk);
    @(posedge clk);
    direct      <= 1'b1;            // request in the middle of the read phase
    direct_csn  <= 1'b1;
    direct_sclk <= 1'b1;
    direct_mosi <= 1'b1;
    @(negedge clk);
    while (busy === 1'b1)
    begin
      check("adxl_csn during burst", 0, adxl_csn);
      check("adxl_mosi during burst", 0, adxl_mosi);
      @(negedge clk);
    end
    finish_burst(base);
    @(posedge clk);
    direct_csn <= 1'b0;             // opposite of the idle csn
    @(negedge clk);
    check("adxl_csn after burst", 0, adxl_csn);
    check("adxl_sclk after burst", 1, adxl_sclk);   // host pins now
    check("adxl_mosi after burst", 1, adxl_mosi);
    @(posedge clk);
    direct      <= 1'b0;
    direct_csn  <= 1'b1;
    direct_sclk <= 1'b0;
    direct_mosi <= 1'b0;
    repeat (3) @(posedge clk);
    for (int i = 0; i < LEN_READ; i++)
      random_byte(burst_bytes[i]);
    run_burst(1'b0);
  endtask

  initial
  begin
    rst         = 1'b1;
    sync        = 1'b0;
    direct      = 1'b0;
    direct_mosi = 1'b0;
    direct_sclk = 1'b0;
    direct_csn  = 1'b1;
    rd_addr     = '0;
    exp_wr      = 0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    test_reset();
    test_single_burst();
    test_back_to_back();
    test_direct();
    test_switch();
    $display("Simulation finished: PASS");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("timeout, the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Simulation finished: FAIL");
    $fatal(1, "watchdog");
  end

endmodule

`default_nettype wire

// File: adxl_reader.f
hdl/adxl_pkg.sv
hdl/spi_ctrl_if.sv
hdl/spi_timer.sv
hdl/burst_fsm.sv
hdl/spi_shifter.sv
hdl/sample_buffer.sv
hdl/adxl_reader.sv
tests/adxl_reader_chk.sv
tests/tb_adxl_reader.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the adxl_reader testbench with verilator
# result comes from the fail line in sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_adxl_reader -f adxl_reader.f -o sim_adxl_reader \
  && ./obj_dir/sim_adxl_reader > sim.log 2>&1 \
  || echo "Simulation finished: FAIL" >> sim.log

cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1
grep -q "Simulation finished: PASS" sim.log || exit 1
exit 0
